/* hw/dll_settings.svh */
`ifndef DLL_SETTINGS_SVH
`define DLL_SETTINGS_SVH

// Stream word width
`define DLL_DATA_WIDTH 32
`define DLL_SEQ_WIDTH 12

// Unacknowledged TLPs allowed in flight
`define DLL_MAX_OUTSTANDING 4
`define DLL_INITFC_GAP 16

// Credits advertised in InitFC DLLPs
`define DLL_ADV_PH 8'h20
`define DLL_ADV_PD 12'h100

`endif

/* hw/dll_pkg.sv */
package dll_pkg;

  typedef enum logic [7:0] {
    ACK       = 8'h00,
    NAK       = 8'h10,
    INITFC1_P = 8'h40,
    INITFC2_P = 8'hC0
  } dllp_type_e;

  typedef enum logic [1:0] {
    DL_INACTIVE,
    DL_FC_INIT1,
    DL_FC_INIT2,
    DL_ACTIVE
  } dll_state_e;

  typedef struct packed {
    dllp_type_e  dtype;
    logic [11:0] rsvd;
    logic [11:0] seq;
  } acknak_s;

  typedef struct packed {
    dllp_type_e  dtype;
    logic [1:0]  rsvd_hi;
    logic [7:0]  hdr_fc;
    logic [1:0]  rsvd_lo;
    logic [11:0] data_fc;
  } fc_s;

  // One DLLP word, Ack/Nak or flow control view
  typedef union packed {
    acknak_s acknak;
    fc_s     fc;
  } dllp_word_u;

endpackage

/* hw/dll_stream_if.sv */
`timescale 1ns/1ps
`include "dll_settings.svh"

interface dll_stream_if;

  logic [`DLL_DATA_WIDTH-1:0] data;
  logic                       last;
  logic                       valid;
  logic                       ready;

  modport src (
    output data, last, valid,
    input  ready
  );

  modport snk (
    input  data, last, valid,
    output ready
  );

endinterface

/* hw/dll_link_init.sv */
`timescale 1ns/1ps
`include "dll_settings.svh"

module dll_link_init
  import dll_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       phy_link_up_i,
  input  logic       fc1_seen_i,
  input  logic       fc2_seen_i,
  output dll_state_e link_state_o,
  dll_stream_if.src  dllp_o
);

  localparam int GAP_W = $clog2(`DLL_INITFC_GAP);

  dll_state_e       state_q;
  logic             valid_q;
  logic [GAP_W-1:0] gap_q;
  logic             fc1_pend_q;
  logic             fc2_pend_q;
  logic             word_done;
  logic             no_pending;
  logic             fc1_got;
  logic             fc2_got;
  dllp_word_u       fc_word;

  assign word_done  = valid_q && dllp_o.ready;
  // Output slot is free after this edge
  assign no_pending = !valid_q || dllp_o.ready;
  assign fc1_got    = fc1_pend_q || fc1_seen_i;
  assign fc2_got    = fc2_pend_q || fc2_seen_i;

  always_comb begin
    fc_word            = '0;
    fc_word.fc.dtype   = (state_q == DL_FC_INIT2) ? INITFC2_P : INITFC1_P;
    fc_word.fc.hdr_fc  = `DLL_ADV_PH;
    fc_word.fc.data_fc = `DLL_ADV_PD;
  end

  assign dllp_o.data   = fc_word;
  assign dllp_o.last   = 1'b1;
  assign dllp_o.valid  = valid_q;
  assign link_state_o  = state_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || !phy_link_up_i) begin
      state_q    <= DL_INACTIVE;
      valid_q    <= 1'b0;
      gap_q      <= '0;
      fc1_pend_q <= 1'b0;
      fc2_pend_q <= 1'b0;
    end else begin
      fc1_pend_q <= fc1_got;
      fc2_pend_q <= fc2_got;
      // Repeat timer between InitFC words
      if (word_done) begin
        valid_q <= 1'b0;
        gap_q   <= GAP_W'(`DLL_INITFC_GAP - 1);
      end else if (!valid_q) begin
        if (gap_q != '0) begin
          gap_q <= gap_q - 1'b1;
        end else begin
          valid_q <= 1'b1;
        end
      end
      case (state_q)
        DL_INACTIVE: begin
          state_q    <= DL_FC_INIT1;
          fc1_pend_q <= 1'b0;
          fc2_pend_q <= 1'b0;
        end
        DL_FC_INIT1: begin
          if (fc1_got && no_pending) begin
            state_q <= DL_FC_INIT2;
            valid_q <= 1'b1;
            gap_q   <= '0;
          end
        end
        DL_FC_INIT2: begin
          if (fc2_got && no_pending) begin
            state_q <= DL_ACTIVE;
            valid_q <= 1'b0;
          end
        end
        default: valid_q <= 1'b0;
      endcase
    end
  end

  a_no_fc_outside_init: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q inside {DL_INACTIVE, DL_ACTIVE}) |-> !dllp_o.valid);

endmodule

/* hw/dll_rx_dllp_decode.sv */
`timescale 1ns/1ps
`include "dll_settings.svh"

module dll_rx_dllp_decode
  import dll_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`DLL_DATA_WIDTH-1:0] phy_rx_tdata_i,
  input  logic                      phy_rx_tvalid_i,
  input  logic                      phy_rx_tlast_i,
  output logic                      fc1_seen_o,
  output logic                      fc2_seen_o,
  output logic                      ack_vld_o,
  output logic [`DLL_SEQ_WIDTH-1:0]  ack_seq_o
);

  dllp_word_u rx_word;
  logic       is_acknak;

  assign rx_word   = phy_rx_tdata_i;
  // Nak handled like Ack, no replay
  assign is_acknak = (rx_word.acknak.dtype == ACK) || (rx_word.acknak.dtype == NAK);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fc1_seen_o <= 1'b0;
      fc2_seen_o <= 1'b0;
      ack_vld_o  <= 1'b0;
    end else begin
      fc1_seen_o <= 1'b0;
      fc2_seen_o <= 1'b0;
      ack_vld_o  <= 1'b0;
      if (phy_rx_tvalid_i) begin
        case (rx_word.fc.dtype)
          ACK, NAK:  ack_vld_o  <= 1'b1;
          INITFC1_P: fc1_seen_o <= 1'b1;
          INITFC2_P: fc2_seen_o <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (phy_rx_tvalid_i && is_acknak) begin
      ack_seq_o <= rx_word.acknak.seq;
    end
  end

  // Every DLLP is a single word
  a_dllp_single_word: assert property (@(posedge clk_i) disable iff (rst_i)
    phy_rx_tvalid_i |-> phy_rx_tlast_i);

endmodule

/* hw/dll_tx_seq_framer.sv */
`timescale 1ns/1ps
`include "dll_settings.svh"

module dll_tx_seq_framer
  import dll_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  dll_state_e                link_state_i,
  input  logic [`DLL_DATA_WIDTH-1:0] tlp_tdata_i,
  input  logic                      tlp_tvalid_i,
  input  logic                      tlp_tlast_i,
  output logic                      tlp_tready_o,
  input  logic                      ack_vld_i,
  input  logic [`DLL_SEQ_WIDTH-1:0]  ack_seq_i,
  dll_stream_if.src                 tlp_o
);

  localparam int SW = `DLL_SEQ_WIDTH;
  localparam logic [SW-1:0] MAX_OUT = SW'(`DLL_MAX_OUTSTANDING);

  typedef enum logic {ST_SEQ, ST_PAYLOAD} frm_state_e;

  frm_state_e    frm_q;
  logic [SW-1:0] next_seq_q;
  logic [SW-1:0] acked_seq_q;
  logic [SW-1:0] outstanding;
  logic          active;
  logic          window_ok;

  // Wraps modulo 4096 with the sequence space
  assign outstanding = next_seq_q - acked_seq_q;
  assign active      = (link_state_i == DL_ACTIVE);
  assign window_ok   = (outstanding < MAX_OUT);

  always_comb begin
    if (frm_q == ST_SEQ) begin
      tlp_o.valid  = active && tlp_tvalid_i && window_ok;
      tlp_o.data   = {{(`DLL_DATA_WIDTH - SW){1'b0}}, next_seq_q};
      tlp_o.last   = 1'b0;
      tlp_tready_o = 1'b0;
    end else begin
      tlp_o.valid  = tlp_tvalid_i;
      tlp_o.data   = tlp_tdata_i;
      tlp_o.last   = tlp_tlast_i;
      tlp_tready_o = tlp_o.ready;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || !active) begin
      frm_q       <= ST_SEQ;
      next_seq_q  <= '0;
      acked_seq_q <= '0;
    end else begin
      if (tlp_o.valid && tlp_o.ready) begin
        if (frm_q == ST_SEQ) begin
          frm_q <= ST_PAYLOAD;
        end else if (tlp_tlast_i) begin
          frm_q      <= ST_SEQ;
          next_seq_q <= next_seq_q + 1'b1;
        end
      end
      if (ack_vld_i) begin
        acked_seq_q <= ack_seq_i + 1'b1;
      end
    end
  end

  a_window_limit: assert property (@(posedge clk_i) disable iff (rst_i)
    outstanding <= MAX_OUT);

endmodule

/* hw/dll_tx_arbiter.sv */
`timescale 1ns/1ps
`include "dll_settings.svh"

module dll_tx_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_i,
  dll_stream_if.snk                 dllp_i,
  dll_stream_if.snk                 tlp_i,
  output logic [`DLL_DATA_WIDTH-1:0] phy_tx_tdata_o,
  output logic                      phy_tx_tvalid_o,
  output logic                      phy_tx_tlast_o,
  input  logic                      phy_tx_tready_i
);

  logic lock_q;
  logic sel_dllp_q;
  logic grant_dllp;

  // DLLPs win when no packet holds the output
  assign grant_dllp = lock_q ? sel_dllp_q : dllp_i.valid;

  assign phy_tx_tvalid_o = grant_dllp ? dllp_i.valid : tlp_i.valid;
  assign phy_tx_tdata_o  = grant_dllp ? dllp_i.data  : tlp_i.data;
  assign phy_tx_tlast_o  = grant_dllp ? dllp_i.last  : tlp_i.last;

  assign dllp_i.ready = grant_dllp && phy_tx_tready_i;
  assign tlp_i.ready  = !grant_dllp && phy_tx_tready_i;

  // Grant sticks from first offered word until last transfers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q     <= 1'b0;
      sel_dllp_q <= 1'b0;
    end else if (phy_tx_tvalid_o) begin
      lock_q     <= !(phy_tx_tready_i && phy_tx_tlast_o);
      sel_dllp_q <= grant_dllp;
    end
  end

  a_phy_tx_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (phy_tx_tvalid_o && !phy_tx_tready_i) |=>
      (phy_tx_tvalid_o && $stable(phy_tx_tdata_o) && $stable(phy_tx_tlast_o)));

endmodule

/* hw/dll_top.sv */
`timescale 1ns/1ps
`include "dll_settings.svh"

module dll_top
  import dll_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      phy_link_up_i,
  input  logic [`DLL_DATA_WIDTH-1:0] tlp_tdata_i,
  input  logic                      tlp_tvalid_i,
  input  logic                      tlp_tlast_i,
  output logic                      tlp_tready_o,
  input  logic [`DLL_DATA_WIDTH-1:0] phy_rx_tdata_i,
  input  logic                      phy_rx_tvalid_i,
  input  logic                      phy_rx_tlast_i,
  output logic                      phy_rx_tready_o,
  output logic [`DLL_DATA_WIDTH-1:0] phy_tx_tdata_o,
  output logic                      phy_tx_tvalid_o,
  output logic                      phy_tx_tlast_o,
  input  logic                      phy_tx_tready_i,
  output logic                      link_active_o
);

  dll_state_e               link_state;
  logic                     fc1_seen;
  logic                     fc2_seen;
  logic                     ack_vld;
  logic [`DLL_SEQ_WIDTH-1:0] ack_seq;
  logic                     arb_rst;

  dll_stream_if dllp_s ();
  dll_stream_if tlp_s ();

  // Link loss flushes the packet lock
  assign arb_rst         = rst_i || !phy_link_up_i;
  assign phy_rx_tready_o = 1'b1;
  assign link_active_o   = (link_state == DL_ACTIVE);

  dll_rx_dllp_decode u_decode (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .phy_rx_tdata_i  (phy_rx_tdata_i),
    .phy_rx_tvalid_i (phy_rx_tvalid_i),
    .phy_rx_tlast_i  (phy_rx_tlast_i),
    .fc1_seen_o      (fc1_seen),
    .fc2_seen_o      (fc2_seen),
    .ack_vld_o       (ack_vld),
    .ack_seq_o       (ack_seq)
  );

  dll_link_init u_link_init (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .phy_link_up_i (phy_link_up_i),
    .fc1_seen_i    (fc1_seen),
    .fc2_seen_i    (fc2_seen),
    .link_state_o  (link_state),
    .dllp_o        (dllp_s.src)
  );

  dll_tx_seq_framer u_framer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .link_state_i (link_state),
    .tlp_tdata_i  (tlp_tdata_i),
    .tlp_tvalid_i (tlp_tvalid_i),
    .tlp_tlast_i  (tlp_tlast_i),
    .tlp_tready_o (tlp_tready_o),
    .ack_vld_i    (ack_vld),
    .ack_seq_i    (ack_seq),
    .tlp_o        (tlp_s.src)
  );

  dll_tx_arbiter u_arbiter (
    .clk_i           (clk_i),
    .rst_i           (arb_rst),
    .dllp_i          (dllp_s.snk),
    .tlp_i           (tlp_s.snk),
    .phy_tx_tdata_o  (phy_tx_tdata_o),
    .phy_tx_tvalid_o (phy_tx_tvalid_o),
    .phy_tx_tlast_o  (phy_tx_tlast_o),
    .phy_tx_tready_i (phy_tx_tready_i)
  );

endmodule

/* sim/dll_tb.sv */
`timescale 1ns/1ps
`include "dll_settings.svh"

module dll_tb;

  typedef enum int {LINK_UP, LINK_DOWN, PHY_DLLP, SEND_TLP, STALL} op_e;

  localparam int NSTEPS  = 19;
  localparam int TIMEOUT = NSTEPS * 200;
  localparam int HOLD    = 20;
  // Operand flag of SEND_TLP when the ack window is full
  localparam logic [31:0] BLOCKED  = 32'h8000_0000;
  localparam logic [7:0]  ACK_TYPE = 8'h00;
  localparam logic [7:0]  NAK_TYPE = 8'h10;
  localparam logic [7:0]  FC1_TYPE = 8'h40;
  localparam logic [7:0]  FC2_TYPE = 8'hC0;

  logic                       clk_i;
  logic                       rst_i;
  logic                       phy_link_up_i;
  logic [`DLL_DATA_WIDTH-1:0] tlp_tdata_i;
  logic                       tlp_tvalid_i;
  logic                       tlp_tlast_i;
  logic                       tlp_tready_o;
  logic [`DLL_DATA_WIDTH-1:0] phy_rx_tdata_i;
  logic                       phy_rx_tvalid_i;
  logic                       phy_rx_tlast_i;
  logic                       phy_rx_tready_o;
  logic [`DLL_DATA_WIDTH-1:0] phy_tx_tdata_o;
  logic                       phy_tx_tvalid_o;
  logic                       phy_tx_tlast_o;
  logic                       phy_tx_tready_i = 1'b1;
  logic                       link_active_o;

  string       step_name [NSTEPS];
  op_e         step_op [NSTEPS];
  logic [31:0] step_arg [NSTEPS];
  logic [31:0] step_exp [NSTEPS];
  int          n_steps;
  int          cycles = 0;
  int          seed;
  int          error_count;
  logic        stall_on;
  logic [7:0]  tlp_id;
  // InitFC words captured apart from TLP words as {last, data}
  logic [31:0] fc_q[$];
  logic [32:0] tlp_q[$];
  logic [32:0] exp_q[$];

  dll_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Advertised credits hdr_fc 8'h20 and data_fc 12'h100
  function automatic logic [31:0] fc_word(input logic [7:0] dtype);
    return {dtype, 2'b00, 8'h20, 2'b00, 12'h100};
  endfunction

  function automatic logic [31:0] acknak_word(input logic [7:0] dtype, input logic [11:0] seq);
    return {dtype, 12'h000, seq};
  endfunction

  function automatic logic [31:0] payload_word(input logic [7:0] id, input int idx);
    return {8'h5A, id, 16'(idx)};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic add_step(input string name, input op_e op, input logic [31:0] arg,
                          input logic [31:0] exp);
    step_name[n_steps] = name;
    step_op[n_steps]   = op;
    step_arg[n_steps]  = arg;
    step_exp[n_steps]  = exp;
    n_steps++;
  endtask

  task automatic send_dllp(input logic [31:0] word);
    phy_rx_tdata_i  = word;
    phy_rx_tvalid_i = 1'b1;
    phy_rx_tlast_i  = 1'b1;
    next_cycle();
    phy_rx_tvalid_i = 1'b0;
    phy_rx_tlast_i  = 1'b0;
  endtask

  task automatic send_tlp(input string name, input int len, input bit blocked,
                          input logic [11:0] seq);
    logic        acc;
    logic [32:0] want;
    logic [32:0] got;
    if (blocked) begin
      // First word stays offered for the next SEND_TLP step
      tlp_tdata_i  = payload_word(tlp_id, 0);
      tlp_tvalid_i = 1'b1;
      tlp_tlast_i  = (len == 1);
      repeat (HOLD) begin
        @(negedge clk_i);
        check(name, 32'd0, 32'(tlp_tready_o));
        next_cycle();
      end
      check(name, 32'd0, 32'(tlp_q.size()));
    end else begin
      exp_q.push_back({1'b0, 20'd0, seq});
      for (int i = 0; i < len; i++) begin
        exp_q.push_back({i == len - 1, payload_word(tlp_id, i)});
      end
      for (int i = 0; i < len; i++) begin
        tlp_tdata_i  = payload_word(tlp_id, i);
        tlp_tvalid_i = 1'b1;
        tlp_tlast_i  = (i == len - 1);
        do begin
          @(negedge clk_i);
          acc = tlp_tready_o;
          next_cycle();
        end while (!acc);
      end
      tlp_tvalid_i = 1'b0;
      tlp_tlast_i  = 1'b0;
      tlp_id++;
      while (tlp_q.size() < exp_q.size()) next_cycle();
      while (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        got  = tlp_q.pop_front();
        check(name, want[31:0], got[31:0]);
        check({name, " last"}, 32'(want[32]), 32'(got[32]));
      end
      check({name, " extra words"}, 32'd0, 32'(tlp_q.size()));
    end
  endtask

  task automatic run_step(input string name, input op_e op, input logic [31:0] arg,
                          input logic [31:0] exp);
    logic [31:0] w;
    case (op)
      LINK_UP: begin
        fc_q.delete();
        phy_link_up_i = 1'b1;
        for (int i = 0; i < int'(arg); i++) begin
          while (fc_q.size() == 0) next_cycle();
          check(name, exp, fc_q.pop_front());
        end
      end
      LINK_DOWN: begin
        // Nothing from link init once active
        check({name, " initfc after active"}, 32'd0, 32'(fc_q.size()));
        phy_link_up_i = 1'b0;
        next_cycle();
        check(name, exp, 32'(link_active_o));
      end
      PHY_DLLP: begin
        check({name, " rx ready"}, 32'd1, 32'(phy_rx_tready_o));
        send_dllp(arg);
        if (arg[31:24] == FC1_TYPE) begin
          // Repeats of InitFC1 may still come before InitFC2
          do begin
            while (fc_q.size() == 0) next_cycle();
            w = fc_q.pop_front();
          end while (w == fc_word(FC1_TYPE));
          check(name, exp, w);
        end else begin
          // Link state settles within a few cycles of the DLLP
          for (int i = 0; i < 4 && link_active_o !== exp[0]; i++) next_cycle();
          if (arg[31:24] == FC2_TYPE) fc_q.delete();
          check(name, exp, 32'(link_active_o));
        end
      end
      default: begin
        stall_on = (op == STALL);
        send_tlp(name, int'(arg[15:0]), arg[31], exp[11:0]);
        stall_on = 1'b0;
      end
    endcase
  endtask

  task automatic load_table();
    add_step("initfc1_tx",     LINK_UP,   32'd2, fc_word(FC1_TYPE));
    add_step("rx_initfc1",     PHY_DLLP,  fc_word(FC1_TYPE), fc_word(FC2_TYPE));
    add_step("rx_initfc2",     PHY_DLLP,  fc_word(FC2_TYPE), 32'd1);
    add_step("tlp_seq0",       SEND_TLP,  32'd3, 32'd0);
    add_step("tlp_seq1",       SEND_TLP,  32'd1, 32'd1);
    add_step("tlp_seq2",       SEND_TLP,  32'd5, 32'd2);
    add_step("tlp_seq3",       SEND_TLP,  32'd2, 32'd3);
    add_step("window_full",    SEND_TLP,  BLOCKED | 32'd4, 32'd4);
    add_step("rx_ack1",        PHY_DLLP,  acknak_word(ACK_TYPE, 12'd1), 32'd1);
    add_step("tlp_seq4",       SEND_TLP,  32'd4, 32'd4);
    add_step("tlp_seq5",       SEND_TLP,  32'd2, 32'd5);
    add_step("rx_nak5",        PHY_DLLP,  acknak_word(NAK_TYPE, 12'd5), 32'd1);
    add_step("stall_seq6",     STALL,     32'd6, 32'd6);
    add_step("stall_seq7",     STALL,     32'd3, 32'd7);
    add_step("link_down",      LINK_DOWN, 32'd0, 32'd0);
    add_step("relink_initfc1", LINK_UP,   32'd2, fc_word(FC1_TYPE));
    add_step("relink_rx_fc1",  PHY_DLLP,  fc_word(FC1_TYPE), fc_word(FC2_TYPE));
    add_step("relink_rx_fc2",  PHY_DLLP,  fc_word(FC2_TYPE), 32'd1);
    add_step("relink_seq0",    SEND_TLP,  32'd2, 32'd0);
  endtask

  // PHY model
  always @(posedge clk_i) begin
    if (phy_tx_tvalid_o && phy_tx_tready_i) begin
      if (phy_tx_tlast_o && (phy_tx_tdata_o[31:24] inside {FC1_TYPE, FC2_TYPE})) begin
        fc_q.push_back(phy_tx_tdata_o);
      end else begin
        tlp_q.push_back({phy_tx_tlast_o, phy_tx_tdata_o});
      end
    end
  end

  always @(posedge clk_i) begin
    #1;
    phy_tx_tready_i = stall_on ? 1'($random(seed)) : 1'b1;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_i           = 1'b1;
    phy_link_up_i   = 1'b0;
    tlp_tdata_i     = '0;
    tlp_tvalid_i    = 1'b0;
    tlp_tlast_i     = 1'b0;
    phy_rx_tdata_i  = '0;
    phy_rx_tvalid_i = 1'b0;
    phy_rx_tlast_i  = 1'b0;
    stall_on        = 1'b0;
    seed            = 32'hba29;
    error_count     = 0;
    n_steps         = 0;
    tlp_id          = 8'd0;
    load_table();
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check("reset link_active", 32'd0, 32'(link_active_o));
    check("reset phy_tx_tvalid", 32'd0, 32'(phy_tx_tvalid_o));
    check("reset tlp_tready", 32'd0, 32'(tlp_tready_o));
    for (int s = 0; s < n_steps; s++) begin
      run_step(step_name[s], step_op[s], step_arg[s], step_exp[s]);
    end
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/dll_pkg.sv
hw/dll_stream_if.sv
hw/dll_link_init.sv
hw/dll_rx_dllp_decode.sv
hw/dll_tx_seq_framer.sv
hw/dll_tx_arbiter.sv
hw/dll_top.sv
sim/dll_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module dll_tb -f vlog.f \
    -Mdir obj_dir -o Vdll_tb; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vdll_tb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
